/* hdl/emu_params.svh */
`ifndef EMU_PARAMS_SVH
`define EMU_PARAMS_SVH

// Number of model trigger inputs, 1 to 128
`define EMU_TRIG_COUNT 40

// Host clocks per model tick
`define EMU_TICK_DIV 4

// Shift cycles in one scan pass
`define EMU_SCAN_LEN 24

// Mailbox entries, power of two and at least 2
`define EMU_UART_DEPTH 8

`endif

/* hdl/emu_bus_pkg.sv */
`default_nettype none

package emu_bus_pkg;

    typedef logic [11:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Host side APB request
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        reg_addr_t paddr;
        reg_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        reg_data_t prdata;
        logic      pready;
    } apb_rsp_t;

    // Single cycle strobes into the register block
    typedef struct packed {
        logic      wen;
        reg_addr_t waddr;
        reg_data_t wdata;
        logic      ren;
        reg_addr_t raddr;
    } reg_req_t;

    typedef enum logic {
        IDLE,
        READ_WAIT
    } apb_state_e;

endpackage

`default_nettype wire

/* hdl/emu_ctrl_pkg.sv */
`default_nettype none

`include "emu_params.svh"

package emu_ctrl_pkg;

    typedef logic [`EMU_TRIG_COUNT-1:0] trig_vec_t;

    typedef logic [63:0] tick_cnt_t;
    typedef logic [31:0] step_cnt_t;
    typedef logic [7:0]  uart_byte_t;

    // Lines to the model during a scan pass
    typedef struct packed {
        logic scan_en;
        logic scan_dir;
    } scan_ctl_t;

    typedef enum logic {
        IDLE,
        SHIFT
    } scan_state_e;

endpackage

`default_nettype wire

/* hdl/emu_apb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module emu_apb_bridge (
    input  wire                    host_clk,
    input  wire                    host_rst,
    input  wire emu_bus_pkg::apb_req_t  apb_req,
    output emu_bus_pkg::apb_rsp_t  apb_rsp,
    output emu_bus_pkg::reg_req_t  reg_req,
    input  wire emu_bus_pkg::reg_data_t reg_rdata
);

    emu_bus_pkg::apb_state_e state;
    emu_bus_pkg::reg_data_t  rdata_q;
    logic                    access;

    // First access cycle of a transfer
    assign access = (state == emu_bus_pkg::IDLE) && apb_req.psel && apb_req.penable;

    always_comb begin
        reg_req.wen   = access && apb_req.pwrite;
        reg_req.waddr = apb_req.paddr;
        reg_req.wdata = apb_req.pwdata;
        reg_req.ren   = access && !apb_req.pwrite;
        reg_req.raddr = apb_req.paddr;
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            state <= emu_bus_pkg::IDLE;
        end else begin
            case (state)
                emu_bus_pkg::IDLE: begin
                    if (access && !apb_req.pwrite) begin
                        state <= emu_bus_pkg::READ_WAIT;
                    end
                end
                default: begin
                    state <= emu_bus_pkg::IDLE;
                end
            endcase
        end
    end

    // Capture read data on the read strobe
    always_ff @(posedge host_clk) begin
        if (reg_req.ren) begin
            rdata_q <= reg_rdata;
        end
    end

    // Writes finish at once, reads one cycle later
    assign apb_rsp.pready = (access && apb_req.pwrite) || (state == emu_bus_pkg::READ_WAIT);
    assign apb_rsp.prdata = rdata_q;

endmodule

`default_nettype wire

/* hdl/emu_sys_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "emu_params.svh"

module emu_sys_ctrl (
    input  wire                          host_clk,
    input  wire                          host_rst,
    input  wire emu_bus_pkg::reg_req_t   reg_req,
    output emu_bus_pkg::reg_data_t       reg_rdata,
    input  wire                          tick,
    input  wire                          model_busy,
    input  wire emu_ctrl_pkg::trig_vec_t trig,
    output logic                         run_mode,
    output logic                         scan_mode,
    output logic                         scan_start,
    output logic                         scan_dir,
    input  wire                          scan_running,
    input  wire                          tx_valid,
    input  wire emu_ctrl_pkg::uart_byte_t tx_data,
    output logic                         tx_ready
);

    // Word indices, address bits 11:2
    localparam logic [9:0] MODE_CTRL   = 10'h000;
    localparam logic [9:0] STEP_CNT    = 10'h001;
    localparam logic [9:0] TICK_CNT_LO = 10'h002;
    localparam logic [9:0] TICK_CNT_HI = 10'h003;
    localparam logic [9:0] SCAN_CTRL   = 10'h004;
    localparam logic [9:0] UART_DATA   = 10'h020;
    // Four word windows, address bits 11:4
    localparam logic [7:0] TRIG_STAT   = 8'h10;
    localparam logic [7:0] TRIG_EN     = 8'h11;

    logic [9:0]               wword;
    logic [9:0]               rword;
    logic                     wr_mode;
    logic                     wr_step;
    logic                     wr_tick_lo;
    logic                     wr_tick_hi;
    logic                     wr_scan;
    logic                     wr_trig_en;
    logic                     pause_busy;
    logic                     trig_hit;
    logic                     stop_run;
    logic                     run_tick;
    logic                     scan_dir_q;
    emu_ctrl_pkg::step_cnt_t  step_cnt;
    emu_ctrl_pkg::tick_cnt_t  tick_cnt;
    emu_ctrl_pkg::trig_vec_t  trig_stat;
    emu_ctrl_pkg::trig_vec_t  trig_en;
    logic [127:0]             trig_stat_pad;
    logic [127:0]             trig_en_pad;

    assign wword = reg_req.waddr[11:2];
    assign rword = reg_req.raddr[11:2];

    assign wr_mode    = reg_req.wen && (wword == MODE_CTRL);
    assign wr_step    = reg_req.wen && (wword == STEP_CNT) && !run_mode;
    assign wr_tick_lo = reg_req.wen && (wword == TICK_CNT_LO) && !run_mode;
    assign wr_tick_hi = reg_req.wen && (wword == TICK_CNT_HI) && !run_mode;
    assign wr_scan    = reg_req.wen && (wword == SCAN_CTRL);
    assign wr_trig_en = reg_req.wen && (reg_req.waddr[11:4] == TRIG_EN);

    assign trig_hit = |(trig_en & trig);
    assign run_tick = run_mode && tick;
    assign stop_run = run_tick && (pause_busy || trig_hit || step_cnt == 32'd1);

    // Run and pause handshake
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            run_mode   <= 1'b0;
            pause_busy <= 1'b0;
        end else if (stop_run) begin
            run_mode   <= 1'b0;
            pause_busy <= 1'b0;
        end else if (wr_mode) begin
            if (reg_req.wdata[0]) begin
                run_mode   <= 1'b1;
                pause_busy <= 1'b0;
            end else if (run_mode) begin
                pause_busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            scan_mode <= 1'b0;
        end else if (wr_mode) begin
            scan_mode <= reg_req.wdata[1];
        end
    end

    // Zero step count runs without limit
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            step_cnt <= '0;
        end else if (run_tick) begin
            if (step_cnt != '0) begin
                step_cnt <= step_cnt - 32'd1;
            end
        end else if (wr_step) begin
            step_cnt <= reg_req.wdata;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            tick_cnt <= '0;
        end else if (run_tick) begin
            tick_cnt <= tick_cnt + 64'd1;
        end else begin
            if (wr_tick_lo) begin
                tick_cnt[31:0] <= reg_req.wdata;
            end
            if (wr_tick_hi) begin
                tick_cnt[63:32] <= reg_req.wdata;
            end
        end
    end

    // Direction is held while a pass is in flight
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            scan_dir_q <= 1'b0;
        end else if (wr_scan && !scan_running) begin
            scan_dir_q <= reg_req.wdata[1];
        end
    end

    assign scan_start = wr_scan && reg_req.wdata[0];
    // New direction travels with the start pulse
    assign scan_dir   = scan_start ? reg_req.wdata[1] : scan_dir_q;

    // Snapshot of the triggers, frozen once stopped
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            trig_stat <= '0;
        end else if (run_mode) begin
            trig_stat <= trig;
        end
    end

    // Each 32-bit window owns one slice of the enables
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            trig_en <= '0;
        end else if (wr_trig_en) begin
            for (int i = 0; i < `EMU_TRIG_COUNT; i++) begin
                if (int'(reg_req.waddr[3:2]) == i / 32) begin
                    trig_en[i] <= reg_req.wdata[i % 32];
                end
            end
        end
    end

    assign trig_stat_pad = 128'(trig_stat);
    assign trig_en_pad   = 128'(trig_en);

    // Mailbox pops on a read of UART_DATA
    assign tx_ready = reg_req.ren && (rword == UART_DATA);

    always_comb begin
        reg_rdata = '0;
        if (reg_req.raddr[11:4] == TRIG_STAT) begin
            reg_rdata = trig_stat_pad[reg_req.raddr[3:2]*32 +: 32];
        end else if (reg_req.raddr[11:4] == TRIG_EN) begin
            reg_rdata = trig_en_pad[reg_req.raddr[3:2]*32 +: 32];
        end else begin
            case (rword)
                MODE_CTRL:   reg_rdata = {28'd0, model_busy, pause_busy, scan_mode, run_mode};
                STEP_CNT:    reg_rdata = step_cnt;
                TICK_CNT_LO: reg_rdata = tick_cnt[31:0];
                TICK_CNT_HI: reg_rdata = tick_cnt[63:32];
                SCAN_CTRL:   reg_rdata = {30'd0, scan_dir_q, scan_running};
                UART_DATA:   reg_rdata = {tx_valid, 23'd0, tx_data};
                default:     reg_rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/emu_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "emu_params.svh"

module emu_tick_gen (
    input  wire  host_clk,
    input  wire  host_rst,
    input  wire  model_busy,
    output logic tick
);

    localparam int CW = (`EMU_TICK_DIV > 1) ? $clog2(`EMU_TICK_DIV) : 1;

    logic [CW-1:0] div_cnt;
    logic          at_end;

    assign at_end = (div_cnt == CW'(`EMU_TICK_DIV - 1));

    // Divider freezes while the model is busy
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            div_cnt <= '0;
        end else if (!model_busy) begin
            if (at_end) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + CW'(1);
            end
        end
    end

    assign tick = at_end && !model_busy;

endmodule

`default_nettype wire

/* hdl/emu_scan_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "emu_params.svh"

module emu_scan_engine (
    input  wire                     host_clk,
    input  wire                     host_rst,
    input  wire                     start,
    input  wire                     dir,
    output logic                    running,
    output emu_ctrl_pkg::scan_ctl_t scan_ctl
);

    localparam int CW = (`EMU_SCAN_LEN > 1) ? $clog2(`EMU_SCAN_LEN) : 1;

    emu_ctrl_pkg::scan_state_e state;
    logic [CW-1:0]             shift_cnt;
    logic                      dir_q;

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            state     <= emu_ctrl_pkg::IDLE;
            shift_cnt <= '0;
            dir_q     <= 1'b0;
        end else begin
            case (state)
                emu_ctrl_pkg::IDLE: begin
                    // Start only counts when idle
                    if (start) begin
                        state     <= emu_ctrl_pkg::SHIFT;
                        shift_cnt <= '0;
                        dir_q     <= dir;
                    end
                end
                default: begin
                    if (shift_cnt == CW'(`EMU_SCAN_LEN - 1)) begin
                        state <= emu_ctrl_pkg::IDLE;
                    end else begin
                        shift_cnt <= shift_cnt + CW'(1);
                    end
                end
            endcase
        end
    end

    assign running = (state == emu_ctrl_pkg::SHIFT);

    // Direction only shown to the model during the pass
    assign scan_ctl.scan_en  = running;
    assign scan_ctl.scan_dir = running && dir_q;

endmodule

`default_nettype wire

/* hdl/emu_uart_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "emu_params.svh"

module emu_uart_fifo (
    input  wire                           host_clk,
    input  wire                           host_rst,
    input  wire                           in_valid,
    output logic                          in_ready,
    input  wire emu_ctrl_pkg::uart_byte_t in_data,
    output logic                          out_valid,
    output emu_ctrl_pkg::uart_byte_t      out_data,
    input  wire                           pop
);

    localparam int AW = $clog2(`EMU_UART_DEPTH);

    emu_ctrl_pkg::uart_byte_t mem [`EMU_UART_DEPTH];
    logic [AW-1:0]            wr_ptr;
    logic [AW-1:0]            rd_ptr;
    logic [AW:0]              fill;
    logic                     push;
    logic                     take;

    assign in_ready  = (fill != (AW+1)'(`EMU_UART_DEPTH));
    assign out_valid = (fill != '0);
    assign push      = in_valid && in_ready;
    // Pop on empty does nothing
    assign take      = pop && out_valid;

    always_ff @(posedge host_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (take) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            fill <= fill + (AW+1)'(push) - (AW+1)'(take);
        end
    end

    assign out_data = mem[rd_ptr];

endmodule

`default_nettype wire

/* hdl/emu_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module emu_ctrl_top (
    input  wire                           host_clk,
    input  wire                           host_rst,
    input  wire emu_bus_pkg::apb_req_t    apb_req,
    output emu_bus_pkg::apb_rsp_t         apb_rsp,
    input  wire                           model_busy,
    input  wire emu_ctrl_pkg::trig_vec_t  trig,
    output logic                          run_mode,
    output logic                          scan_mode,
    output emu_ctrl_pkg::scan_ctl_t       scan_ctl,
    input  wire                           uart_valid,
    output logic                          uart_ready,
    input  wire emu_ctrl_pkg::uart_byte_t uart_data
);

    emu_bus_pkg::reg_req_t    reg_req;
    emu_bus_pkg::reg_data_t   reg_rdata;
    logic                     tick;
    logic                     scan_start;
    logic                     scan_dir;
    logic                     scan_running;
    logic                     tx_valid;
    logic                     tx_ready;
    emu_ctrl_pkg::uart_byte_t tx_data;

    emu_apb_bridge i_bridge (
        .host_clk  (host_clk),
        .host_rst  (host_rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .reg_req   (reg_req),
        .reg_rdata (reg_rdata)
    );

    emu_sys_ctrl i_sys_ctrl (
        .host_clk     (host_clk),
        .host_rst     (host_rst),
        .reg_req      (reg_req),
        .reg_rdata    (reg_rdata),
        .tick         (tick),
        .model_busy   (model_busy),
        .trig         (trig),
        .run_mode     (run_mode),
        .scan_mode    (scan_mode),
        .scan_start   (scan_start),
        .scan_dir     (scan_dir),
        .scan_running (scan_running),
        .tx_valid     (tx_valid),
        .tx_data      (tx_data),
        .tx_ready     (tx_ready)
    );

    emu_tick_gen i_tick_gen (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .model_busy (model_busy),
        .tick       (tick)
    );

    emu_scan_engine i_scan_engine (
        .host_clk (host_clk),
        .host_rst (host_rst),
        .start    (scan_start),
        .dir      (scan_dir),
        .running  (scan_running),
        .scan_ctl (scan_ctl)
    );

    emu_uart_fifo i_uart_fifo (
        .host_clk  (host_clk),
        .host_rst  (host_rst),
        .in_valid  (uart_valid),
        .in_ready  (uart_ready),
        .in_data   (uart_data),
        .out_valid (tx_valid),
        .out_data  (tx_data),
        .pop       (tx_ready)
    );

endmodule

`default_nettype wire

/* tb/emu_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "emu_params.svh"

module emu_ctrl_tb;

    localparam int CLK_PERIOD = 8;
    // Cycle budget per test, reset values through mailbox
    localparam int TEST_CYCLES = 150 + 250 + 450 + 450 + 120 + 250;

    localparam emu_bus_pkg::reg_addr_t A_MODE      = 12'h000;
    localparam emu_bus_pkg::reg_addr_t A_STEP      = 12'h004;
    localparam emu_bus_pkg::reg_addr_t A_TICK_LO   = 12'h008;
    localparam emu_bus_pkg::reg_addr_t A_TICK_HI   = 12'h00C;
    localparam emu_bus_pkg::reg_addr_t A_SCAN      = 12'h010;
    localparam emu_bus_pkg::reg_addr_t A_UART      = 12'h080;
    localparam emu_bus_pkg::reg_addr_t A_TRIG_STAT = 12'h100;
    localparam emu_bus_pkg::reg_addr_t A_TRIG_EN   = 12'h110;
    localparam logic [127:0] TRIG_MASK = (128'd1 << `EMU_TRIG_COUNT) - 128'd1;

    logic                     host_clk;
    logic                     host_rst;
    emu_bus_pkg::apb_req_t    apb_req;
    emu_bus_pkg::apb_rsp_t    apb_rsp;
    logic                     model_busy;
    emu_ctrl_pkg::trig_vec_t  trig;
    logic                     run_mode;
    logic                     scan_mode;
    emu_ctrl_pkg::scan_ctl_t  scan_ctl;
    logic                     uart_valid;
    logic                     uart_ready;
    emu_ctrl_pkg::uart_byte_t uart_data;
    logic                     busy_toggle;
    logic                     busy_hold;

    // Shadow of the register state
    logic                     sh_run;
    logic                     sh_pause;
    logic                     sh_scan_mode;
    emu_ctrl_pkg::step_cnt_t  sh_step;
    emu_ctrl_pkg::tick_cnt_t  sh_tick;
    logic                     sh_scan_dir;
    logic                     sh_scan_busy;
    logic [127:0]             sh_trig_stat;
    logic [127:0]             sh_trig_en;
    emu_ctrl_pkg::uart_byte_t sh_uart[$];

    emu_bus_pkg::reg_addr_t   addr_q[$];
    emu_bus_pkg::reg_data_t   exp_q[$];
    emu_bus_pkg::reg_data_t   got_q[$];
    int                       errors = 0;
    int                       checks = 0;

    emu_ctrl_top i_dut (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .model_busy (model_busy),
        .trig       (trig),
        .run_mode   (run_mode),
        .scan_mode  (scan_mode),
        .scan_ctl   (scan_ctl),
        .uart_valid (uart_valid),
        .uart_ready (uart_ready),
        .uart_data  (uart_data)
    );

    initial begin
        host_clk = 1'b0;
        forever #(CLK_PERIOD / 2) host_clk = ~host_clk;
    end

    // Model busy line, random or held
    initial begin
        model_busy <= 1'b0;
        forever begin
            @(posedge host_clk);
            if (busy_toggle) begin
                model_busy <= 1'($urandom % 2);
            end else begin
                model_busy <= busy_hold;
            end
        end
    end

    function automatic string reg_name(input emu_bus_pkg::reg_addr_t addr);
        if (addr[11:4] == 8'h10) return $sformatf("TRIG_STAT[%0d]", addr[3:2]);
        if (addr[11:4] == 8'h11) return $sformatf("TRIG_EN[%0d]", addr[3:2]);
        case (addr)
            A_MODE:    return "MODE_CTRL";
            A_STEP:    return "STEP_CNT";
            A_TICK_LO: return "TICK_CNT_LO";
            A_TICK_HI: return "TICK_CNT_HI";
            A_SCAN:    return "SCAN_CTRL";
            A_UART:    return "UART_DATA";
            default:   return "UNMAPPED";
        endcase
    endfunction

    // Expected read value from the shadow state
    function automatic emu_bus_pkg::reg_data_t ref_value(input emu_bus_pkg::reg_addr_t addr);
        emu_bus_pkg::reg_data_t v;
        v = '0;
        if (addr[11:4] == 8'h10) begin
            v = sh_trig_stat[addr[3:2] * 32 +: 32];
        end else if (addr[11:4] == 8'h11) begin
            v = sh_trig_en[addr[3:2] * 32 +: 32];
        end else begin
            case (addr)
                A_MODE:    v = {28'd0, model_busy, sh_pause, sh_scan_mode, sh_run};
                A_STEP:    v = sh_step;
                A_TICK_LO: v = sh_tick[31:0];
                A_TICK_HI: v = sh_tick[63:32];
                A_SCAN:    v = {30'd0, sh_scan_dir, sh_scan_busy};
                A_UART:    v = (sh_uart.size() > 0) ? {1'b1, 23'd0, sh_uart[0]} : '0;
                default:   v = '0;
            endcase
        end
        return v;
    endfunction

    task automatic apb_xfer(input emu_bus_pkg::reg_addr_t addr, input logic wr,
                            input emu_bus_pkg::reg_data_t wdata,
                            output emu_bus_pkg::reg_data_t rdata);
        emu_bus_pkg::apb_req_t req;
        req = '0;
        req.psel = 1'b1;
        req.pwrite = wr;
        req.paddr = addr;
        req.pwdata = wdata;
        @(posedge host_clk);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge host_clk);
        apb_req <= req;
        @(negedge host_clk);
        while (!apb_rsp.pready) @(negedge host_clk);
        rdata = apb_rsp.prdata;
        @(posedge host_clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input emu_bus_pkg::reg_addr_t addr,
                             input emu_bus_pkg::reg_data_t wdata);
        emu_bus_pkg::reg_data_t unused;
        apb_xfer(addr, 1'b1, wdata, unused);
    endtask

    task automatic apb_read(input emu_bus_pkg::reg_addr_t addr,
                            output emu_bus_pkg::reg_data_t rdata);
        apb_xfer(addr, 1'b0, '0, rdata);
    endtask

    // Read and queue for the compare process
    task automatic check_reg(input emu_bus_pkg::reg_addr_t addr);
        emu_bus_pkg::reg_data_t got;
        // Mode lines to the model follow the MODE_CTRL bits
        if (addr == A_MODE) begin
            @(negedge host_clk);
            if (run_mode !== sh_run) begin
                errors++;
                $display("Fail at %0t: run_mode expected %0b got %0b",
                         $time, sh_run, run_mode);
            end
            if (scan_mode !== sh_scan_mode) begin
                errors++;
                $display("Fail at %0t: scan_mode expected %0b got %0b",
                         $time, sh_scan_mode, scan_mode);
            end
        end
        apb_read(addr, got);
        // Only the valid bit has a meaning on an empty mailbox
        if (addr == A_UART && sh_uart.size() == 0) begin
            got = got & 32'h8000_0000;
        end
        addr_q.push_back(addr);
        exp_q.push_back(ref_value(addr));
        got_q.push_back(got);
        if (addr == A_UART && sh_uart.size() > 0) begin
            void'(sh_uart.pop_front());
        end
    endtask

    task automatic wait_run_clear();
        emu_bus_pkg::reg_data_t v;
        v = 32'd1;
        while (v[0]) apb_read(A_MODE, v);
    endtask

    // Tick count after a run of unknown length
    task automatic sync_tick();
        emu_bus_pkg::reg_data_t lo;
        emu_bus_pkg::reg_data_t hi;
        apb_read(A_TICK_LO, lo);
        apb_read(A_TICK_HI, hi);
        if ({hi, lo} <= sh_tick) begin
            errors++;
            $display("Tick count did not advance during the run at %0t", $time);
        end
        sh_tick = {hi, lo};
    endtask

    initial begin : compare_proc
        emu_bus_pkg::reg_addr_t a;
        emu_bus_pkg::reg_data_t e;
        emu_bus_pkg::reg_data_t g;
        forever begin
            @(negedge host_clk);
            while (got_q.size() > 0) begin
                a = addr_q.pop_front();
                e = exp_q.pop_front();
                g = got_q.pop_front();
                checks++;
                if (g !== e) begin
                    errors++;
                    $display("Fail at %0t: %s expected %h got %h", $time, reg_name(a), e, g);
                end
            end
        end
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Run timed out at %0t before the tests finished", $time);
        $display("Checks: %0d  Errors: %0d", checks, errors + 1);
        $display("tests failed");
        $finish;
    end

    initial begin : main_seq
        emu_bus_pkg::reg_data_t   v;
        emu_bus_pkg::reg_data_t   word;
        logic [127:0]             pattern;
        int                       n;
        int                       en_idx;
        int                       dis_idx;
        int                       scan_cycles;
        logic                     dir;
        logic                     full;
        emu_ctrl_pkg::uart_byte_t b;

        void'($urandom(48));
        sh_run = 1'b0;
        sh_pause = 1'b0;
        sh_scan_mode = 1'b0;
        sh_step = '0;
        sh_tick = '0;
        sh_scan_dir = 1'b0;
        sh_scan_busy = 1'b0;
        sh_trig_stat = '0;
        sh_trig_en = '0;
        host_rst <= 1'b1;
        apb_req <= '0;
        trig <= '0;
        uart_valid <= 1'b0;
        uart_data <= '0;
        busy_toggle <= 1'b0;
        busy_hold <= 1'b0;
        repeat (2) @(posedge host_clk);
        host_rst <= 1'b0;

        // Reset values
        check_reg(A_MODE);
        check_reg(A_STEP);
        check_reg(A_TICK_LO);
        check_reg(A_TICK_HI);
        check_reg(A_SCAN);
        for (int w = 0; w < 4; w++) check_reg(A_TRIG_EN + 12'(4 * w));
        check_reg(A_UART);

        // Step run of N ticks, scan mode set along with run
        word = $urandom;
        v = $urandom;
        apb_write(A_TICK_LO, word);
        apb_write(A_TICK_HI, v);
        sh_tick = {v, word};
        n = 1 + $urandom % 16;
        apb_write(A_STEP, 32'(n));
        sh_step = 32'(n);
        check_reg(A_STEP);
        check_reg(A_TICK_LO);
        apb_write(A_MODE, 32'd3);
        sh_scan_mode = 1'b1;
        wait_run_clear();
        sh_tick = sh_tick + 64'(n);
        sh_step = '0;
        check_reg(A_MODE);
        check_reg(A_STEP);
        check_reg(A_TICK_LO);
        check_reg(A_TICK_HI);

        // Free run, then pause while the model is held busy
        apb_write(A_STEP, 32'd0);
        @(posedge host_clk);
        busy_toggle <= 1'b1;
        apb_write(A_MODE, 32'd1);
        sh_scan_mode = 1'b0;
        repeat (40) @(posedge host_clk);
        busy_toggle <= 1'b0;
        busy_hold <= 1'b1;
        apb_write(A_MODE, 32'd0);
        sh_run = 1'b1;
        sh_pause = 1'b1;
        check_reg(A_MODE);
        @(posedge host_clk);
        busy_hold <= 1'b0;
        v = 32'd1;
        while (v[0]) begin
            apb_read(A_MODE, v);
            if (v[0] && !v[2]) begin
                errors++;
                $display("pause_busy dropped while the run bit was still set at %0t", $time);
            end
        end
        sh_run = 1'b0;
        sh_pause = 1'b0;
        check_reg(A_MODE);
        check_reg(A_STEP);
        sync_tick();

        // One enabled and one disabled trigger bit guaranteed
        en_idx = $urandom % `EMU_TRIG_COUNT;
        dis_idx = (en_idx + 1 + $urandom % (`EMU_TRIG_COUNT - 1)) % `EMU_TRIG_COUNT;
        for (int w = 0; w < 4; w++) begin
            word = $urandom;
            if (en_idx / 32 == w) word[en_idx % 32] = 1'b1;
            if (dis_idx / 32 == w) word[dis_idx % 32] = 1'b0;
            apb_write(A_TRIG_EN + 12'(4 * w), word);
            sh_trig_en[w * 32 +: 32] = word;
        end
        sh_trig_en = sh_trig_en & TRIG_MASK;
        for (int w = 0; w < 4; w++) check_reg(A_TRIG_EN + 12'(4 * w));
        pattern = ~sh_trig_en & TRIG_MASK;
        @(posedge host_clk);
        trig <= pattern[`EMU_TRIG_COUNT-1:0];
        apb_write(A_MODE, 32'd1);
        sh_run = 1'b1;
        repeat (8 * `EMU_TICK_DIV) @(posedge host_clk);
        check_reg(A_MODE);
        pattern = 128'd1 << en_idx;
        @(posedge host_clk);
        trig <= pattern[`EMU_TRIG_COUNT-1:0];
        wait_run_clear();
        sh_run = 1'b0;
        sh_trig_stat = pattern;
        check_reg(A_MODE);
        for (int w = 0; w < 4; w++) check_reg(A_TRIG_STAT + 12'(4 * w));
        sync_tick();
        @(posedge host_clk);
        trig <= '0;

        // Scan pass, length and direction seen by the model
        dir = 1'($urandom % 2);
        sh_scan_dir = dir;
        scan_cycles = 0;
        fork
            begin
                apb_write(A_SCAN, {30'd0, dir, 1'b1});
                sh_scan_busy = 1'b1;
                check_reg(A_SCAN);
            end
            begin
                @(negedge host_clk);
                while (!scan_ctl.scan_en) @(negedge host_clk);
                while (scan_ctl.scan_en) begin
                    scan_cycles++;
                    if (scan_ctl.scan_dir != dir) begin
                        errors++;
                        $display("Fail at %0t: scan_ctl.scan_dir expected %0b got %0b",
                                 $time, dir, scan_ctl.scan_dir);
                    end
                    @(negedge host_clk);
                end
            end
        join
        sh_scan_busy = 1'b0;
        if (scan_cycles != `EMU_SCAN_LEN) begin
            errors++;
            $display("Fail at %0t: scan_ctl.scan_en cycles expected %0d got %0d",
                     $time, `EMU_SCAN_LEN, scan_cycles);
        end
        check_reg(A_SCAN);

        // Fill the mailbox until the model is held off
        n = 0;
        full = 1'b0;
        while (!full && n <= `EMU_UART_DEPTH) begin
            @(posedge host_clk);
            b = 8'($urandom);
            uart_valid <= 1'b1;
            uart_data <= b;
            @(negedge host_clk);
            if (uart_ready) begin
                sh_uart.push_back(b);
                n++;
            end else begin
                full = 1'b1;
            end
        end
        @(posedge host_clk);
        uart_valid <= 1'b0;
        if (n != `EMU_UART_DEPTH) begin
            errors++;
            $display("Fail at %0t: uart_ready bytes accepted expected %0d got %0d",
                     $time, `EMU_UART_DEPTH, n);
        end
        // Last read finds the mailbox empty
        repeat (`EMU_UART_DEPTH + 1) check_reg(A_UART);

        repeat (2) @(negedge host_clk);
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* emu_ctrl_top.f */
+incdir+hdl
hdl/emu_bus_pkg.sv
hdl/emu_ctrl_pkg.sv
hdl/emu_apb_bridge.sv
hdl/emu_sys_ctrl.sv
hdl/emu_tick_gen.sv
hdl/emu_scan_engine.sv
hdl/emu_uart_fifo.sv
hdl/emu_ctrl_top.sv
tb/emu_ctrl_tb.sv

/* Bender.yml */
package:
  name: emu_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/emu_bus_pkg.sv
      - hdl/emu_ctrl_pkg.sv
      - hdl/emu_apb_bridge.sv
      - hdl/emu_sys_ctrl.sv
      - hdl/emu_tick_gen.sv
      - hdl/emu_scan_engine.sv
      - hdl/emu_uart_fifo.sv
      - hdl/emu_ctrl_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/emu_ctrl_tb.sv
